// ==== rtl/rv32i_pipe_pkg.sv ====
package rv32i_pipe_pkg;

    localparam int XLEN       = 32;
    localparam int ORDER_W    = 64;
    localparam int REG_ADDR_W = 5;
    localparam int MASK_W     = 4;

    localparam logic [ORDER_W-1:0] ORDER_RESET = '1; // first increment wraps to zero
    localparam logic [XLEN-1:0]    PC_RESET    = 32'h4000_0000;

    // execute forwarding select
    localparam logic [1:0] FWD_ALU  = 2'b00;
    localparam logic [1:0] FWD_BR   = 2'b01;
    localparam logic [1:0] FWD_UIMM = 2'b10;

    // memory address select
    localparam logic MAR_PC  = 1'b0;
    localparam logic MAR_ALU = 1'b1;

    // memory forwarding select
    localparam logic MEMFWD_RDATA = 1'b0;
    localparam logic MEMFWD_EXE   = 1'b1;

    // load funct3
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // store funct3
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // one funct3 word read as a load width or a store width
    typedef union packed {
        logic [2:0] load_f3;
        logic [2:0] store_f3;
    } mem_funct_u;

endpackage

// ==== rtl/stage_if.sv ====
interface de_em_if;
    import rv32i_pipe_pkg::*;

    logic [1:0]            exefwd_sel;
    logic                  mar_sel;
    logic                  mem_read;
    logic                  mem_write;
    mem_funct_u            mem_funct;
    logic                  memfwd_sel;
    logic                  ld_reg;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       u_imm;
    logic [XLEN-1:0]       pc;

    modport src (
        output exefwd_sel, mar_sel, mem_read, mem_write, mem_funct,
        output memfwd_sel, ld_reg, rd, u_imm, pc
    );
    modport dst (
        input exefwd_sel, mar_sel, mem_read, mem_write, mem_funct,
        input memfwd_sel, ld_reg, rd, u_imm, pc
    );
endinterface

interface em_mw_if;
    import rv32i_pipe_pkg::*;

    logic [XLEN-1:0]       exe_fwd_data;
    logic                  memfwd_sel;
    logic                  ld_reg;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       u_imm;

    modport src (output exe_fwd_data, memfwd_sel, ld_reg, rd, u_imm);
    modport dst (input exe_fwd_data, memfwd_sel, ld_reg, rd, u_imm);
endinterface

// ==== rtl/fetch_decode_reg.sv ====
module fetch_decode_reg (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                fd_load_i,
    input  logic                                fd_flush_i,
    input  logic                                spec_commit_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]     instr_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]     pc_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]     pc_next_i,
    output logic [rv32i_pipe_pkg::XLEN-1:0]     instr_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]     pc_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]     pc_next_o,
    output logic                                fd_valid_o,
    output logic [rv32i_pipe_pkg::ORDER_W-1:0]  commit_order_o
);
    import rv32i_pipe_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd_valid_o <= 1'b0;
            instr_o    <= '0;
            pc_o       <= PC_RESET;
            pc_next_o  <= PC_RESET;
        end else if (fd_flush_i) begin // flush wins over load
            fd_valid_o <= 1'b0;
            instr_o    <= '0;
            pc_o       <= PC_RESET;
            pc_next_o  <= PC_RESET;
        end else if (fd_load_i) begin
            fd_valid_o <= 1'b1;
            instr_o    <= instr_i;
            pc_o       <= pc_i;
            pc_next_o  <= pc_next_i;
        end
    end

    // retire order rewinds by one when a fetched slot is flushed
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_order_o <= ORDER_RESET;
        end else if ((fd_load_i || spec_commit_i) && !fd_flush_i) begin
            commit_order_o <= commit_order_o + ORDER_W'(1);
        end else if (fd_flush_i && !fd_load_i) begin
            commit_order_o <= commit_order_o - ORDER_W'(1);
        end
    end

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        (commit_order_o == ORDER_RESET) |=> (commit_order_o != ORDER_RESET - ORDER_W'(1))
    ) else $error("commit order decremented below its reset value");

endmodule

// ==== rtl/decode_execute_reg.sv ====
module decode_execute_reg (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  de_load_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       pc_i,
    input  logic [1:0]                            exefwd_sel_i,
    input  logic                                  mar_sel_i,
    input  logic                                  mem_read_i,
    input  logic                                  mem_write_i,
    input  rv32i_pipe_pkg::mem_funct_u            mem_funct_i,
    input  logic                                  memfwd_sel_i,
    input  logic                                  ld_reg_i,
    input  logic [rv32i_pipe_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       u_imm_i,
    output logic                                  de_valid_o,
    de_em_if.src                                  de_em
);
    import rv32i_pipe_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            de_valid_o       <= 1'b0;
            de_em.exefwd_sel <= FWD_ALU;
            de_em.mar_sel    <= MAR_PC;
            de_em.mem_read   <= 1'b0;
            de_em.mem_write  <= 1'b0;
            de_em.mem_funct  <= '0;
            de_em.memfwd_sel <= MEMFWD_RDATA;
            de_em.ld_reg     <= 1'b0;
            de_em.rd         <= '0;
            de_em.pc         <= PC_RESET;
        end else if (de_load_i) begin
            de_valid_o       <= 1'b1;
            de_em.exefwd_sel <= exefwd_sel_i;
            de_em.mar_sel    <= mar_sel_i;
            de_em.mem_read   <= mem_read_i;
            de_em.mem_write  <= mem_write_i;
            de_em.mem_funct  <= mem_funct_i;
            de_em.memfwd_sel <= memfwd_sel_i;
            de_em.ld_reg     <= ld_reg_i;
            de_em.rd         <= rd_i;
            de_em.pc         <= pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (de_load_i) de_em.u_imm <= u_imm_i;
    end

    // decoder must never mark one instruction as both load and store
    a_rw_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        de_load_i |-> !(mem_read_i && mem_write_i)
    ) else $error("load and store both set on decode");

endmodule

// ==== rtl/execute_memory_reg.sv ====
module execute_memory_reg (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              em_load_i,
    input  logic                              em_flush_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]   alu_out_i,
    input  logic                              br_en_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]   rs2_data_i,
    de_em_if.dst                              de_em,
    output logic                              em_valid_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]   dmem_addr_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]   dmem_wdata_o,
    output logic [rv32i_pipe_pkg::MASK_W-1:0] dmem_byte_en_o,
    output logic                              dmem_read_o,
    output logic                              dmem_write_o,
    em_mw_if.src                              em_mw
);
    import rv32i_pipe_pkg::*;

    logic [XLEN-1:0]   fwd_data;
    logic [XLEN-1:0]   raw_addr;
    logic [XLEN-1:0]   mem_addr;
    logic [MASK_W-1:0] byte_mask;
    logic              capture;
    logic              mem_access;

    assign capture    = em_load_i && !em_flush_i;
    assign mem_access = de_em.mem_read || de_em.mem_write;

    always_comb begin
        case (de_em.exefwd_sel)
            FWD_BR:   fwd_data = {{(XLEN-1){1'b0}}, br_en_i};
            FWD_UIMM: fwd_data = de_em.u_imm;
            default:  fwd_data = alu_out_i;
        endcase
    end

    assign raw_addr = (de_em.mar_sel == MAR_PC) ? de_em.pc : alu_out_i;

    always_comb begin
        byte_mask = '0;
        if (de_em.mem_read) begin
            case (de_em.mem_funct.load_f3)
                F3_LW:         byte_mask = 4'b1111;
                F3_LH, F3_LHU: byte_mask = MASK_W'(4'b0011) << raw_addr[1:0];
                F3_LB, F3_LBU: byte_mask = MASK_W'(4'b0001) << raw_addr[1:0];
                default:       byte_mask = '0;
            endcase
        end else if (de_em.mem_write) begin
            case (de_em.mem_funct.store_f3)
                F3_SW:   byte_mask = 4'b1111;
                F3_SH:   byte_mask = MASK_W'(4'b0011) << raw_addr[1:0];
                F3_SB:   byte_mask = MASK_W'(4'b0001) << raw_addr[1:0];
                default: byte_mask = '0;
            endcase
        end
    end

    // sub-word accesses go out word aligned
    assign mem_addr = (byte_mask == 4'b1111) ? raw_addr : {raw_addr[XLEN-1:2], 2'b00};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            em_valid_o         <= 1'b0;
            em_mw.ld_reg       <= 1'b0;
            em_mw.exe_fwd_data <= '0;
        end else if (em_flush_i) begin
            em_valid_o         <= 1'b0;
            em_mw.ld_reg       <= 1'b0; // no writeback from a flushed slot
            em_mw.exe_fwd_data <= '0;
        end else if (em_load_i) begin
            em_valid_o         <= 1'b1;
            em_mw.ld_reg       <= de_em.ld_reg;
            em_mw.exe_fwd_data <= fwd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            em_mw.memfwd_sel <= de_em.memfwd_sel;
            em_mw.rd         <= de_em.rd;
            em_mw.u_imm      <= de_em.u_imm;
        end
    end

    // data memory port
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dmem_byte_en_o <= '0;
            dmem_read_o    <= 1'b0;
            dmem_write_o   <= 1'b0;
        end else if (capture) begin
            dmem_read_o  <= de_em.mem_read;
            dmem_write_o <= de_em.mem_write;
            if (mem_access) dmem_byte_en_o <= byte_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (capture && mem_access) begin
            dmem_addr_o  <= mem_addr;
            dmem_wdata_o <= rs2_data_i; // unshifted store data
        end
    end

    a_mask_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        (capture && mem_access) |=> (dmem_byte_en_o != '0)
    ) else $error("memory access captured with empty byte mask");

endmodule

// ==== rtl/memory_writeback_reg.sv ====
module memory_writeback_reg (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  mw_load_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       dmem_rdata_i,
    input  logic                                  wb_fwd_load_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       wb_fwd_data_i,
    em_mw_if.dst                                  em_mw,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       mem_fwd_data_o,
    output logic                                  mw_ld_reg_o,
    output logic [rv32i_pipe_pkg::REG_ADDR_W-1:0] mw_rd_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       mw_u_imm_o,
    output logic                                  mw_valid_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       wb_fwd_data_o
);
    import rv32i_pipe_pkg::*;

    logic [XLEN-1:0] mem_fwd_sel_data;

    assign mem_fwd_sel_data = (em_mw.memfwd_sel == MEMFWD_EXE) ? em_mw.exe_fwd_data
                                                               : dmem_rdata_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mw_valid_o  <= 1'b0;
            mw_ld_reg_o <= 1'b0;
        end else if (mw_load_i) begin
            mw_valid_o  <= 1'b1;
            mw_ld_reg_o <= em_mw.ld_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (mw_load_i) begin
            mem_fwd_data_o <= mem_fwd_sel_data;
            mw_rd_o        <= em_mw.rd;
            mw_u_imm_o     <= em_mw.u_imm;
        end
    end

    // writeback forwarding has its own strobe
    always_ff @(posedge clk) begin
        if (wb_fwd_load_i) wb_fwd_data_o <= wb_fwd_data_i;
    end

endmodule

// ==== rtl/rv32i_pipe_regs.sv ====
module rv32i_pipe_regs (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  fd_load_i,
    input  logic                                  fd_flush_i,
    input  logic                                  spec_commit_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       instr_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       pc_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       pc_next_i,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       instr_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       pc_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       pc_next_o,
    output logic                                  fd_valid_o,
    output logic [rv32i_pipe_pkg::ORDER_W-1:0]    commit_order_o,
    input  logic                                  de_load_i,
    input  logic [1:0]                            exefwd_sel_i,
    input  logic                                  mar_sel_i,
    input  logic                                  mem_read_i,
    input  logic                                  mem_write_i,
    input  rv32i_pipe_pkg::mem_funct_u            mem_funct_i,
    input  logic                                  memfwd_sel_i,
    input  logic                                  ld_reg_i,
    input  logic [rv32i_pipe_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       u_imm_i,
    output logic                                  de_valid_o,
    input  logic                                  em_load_i,
    input  logic                                  em_flush_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       alu_out_i,
    input  logic                                  br_en_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       rs2_data_i,
    output logic                                  em_valid_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       dmem_addr_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       dmem_wdata_o,
    output logic [rv32i_pipe_pkg::MASK_W-1:0]     dmem_byte_en_o,
    output logic                                  dmem_read_o,
    output logic                                  dmem_write_o,
    input  logic                                  mw_load_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       dmem_rdata_i,
    input  logic                                  wb_fwd_load_i,
    input  logic [rv32i_pipe_pkg::XLEN-1:0]       wb_fwd_data_i,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       mem_fwd_data_o,
    output logic                                  mw_ld_reg_o,
    output logic [rv32i_pipe_pkg::REG_ADDR_W-1:0] mw_rd_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       mw_u_imm_o,
    output logic                                  mw_valid_o,
    output logic [rv32i_pipe_pkg::XLEN-1:0]       wb_fwd_data_o
);

    de_em_if de_em ();
    em_mw_if em_mw ();

    fetch_decode_reg i_fd (
        .clk, .rst, .fd_load_i, .fd_flush_i, .spec_commit_i,
        .instr_i, .pc_i, .pc_next_i,
        .instr_o, .pc_o, .pc_next_o, .fd_valid_o, .commit_order_o
    );

    decode_execute_reg i_de (
        .clk, .rst, .de_load_i,
        .pc_i         (pc_o), // decode PC follows the fetch/decode register
        .exefwd_sel_i, .mar_sel_i, .mem_read_i, .mem_write_i, .mem_funct_i,
        .memfwd_sel_i, .ld_reg_i, .rd_i, .u_imm_i,
        .de_valid_o,
        .de_em        (de_em.src)
    );

    execute_memory_reg i_em (
        .clk, .rst, .em_load_i, .em_flush_i, .alu_out_i, .br_en_i, .rs2_data_i,
        .de_em        (de_em.dst),
        .em_valid_o, .dmem_addr_o, .dmem_wdata_o, .dmem_byte_en_o,
        .dmem_read_o, .dmem_write_o,
        .em_mw        (em_mw.src)
    );

    memory_writeback_reg i_mw (
        .clk, .rst, .mw_load_i, .dmem_rdata_i, .wb_fwd_load_i, .wb_fwd_data_i,
        .em_mw        (em_mw.dst),
        .mem_fwd_data_o, .mw_ld_reg_o, .mw_rd_o, .mw_u_imm_o, .mw_valid_o,
        .wb_fwd_data_o
    );

endmodule

// ==== tb/tb_rv32i_pipe_regs.sv ====
module tb_rv32i_pipe_regs;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32i_pipe_pkg::*;

    localparam int STIM_CYCLES = 1500;
    localparam int CYCLE_LIMIT = 2000; // stimulus plus reset and drain margin

    logic clk, rst;
    logic fd_load_i, fd_flush_i, spec_commit_i;
    logic [XLEN-1:0] instr_i, pc_i, pc_next_i, instr_o, pc_o, pc_next_o;
    logic fd_valid_o;
    logic [ORDER_W-1:0] commit_order_o;
    logic de_load_i, mar_sel_i, mem_read_i, mem_write_i, memfwd_sel_i, ld_reg_i;
    logic [1:0] exefwd_sel_i;
    mem_funct_u mem_funct_i;
    logic [REG_ADDR_W-1:0] rd_i, mw_rd_o;
    logic [XLEN-1:0] u_imm_i, alu_out_i, rs2_data_i, dmem_rdata_i, wb_fwd_data_i;
    logic de_valid_o, em_load_i, em_flush_i, br_en_i, em_valid_o;
    logic [XLEN-1:0] dmem_addr_o, dmem_wdata_o, mem_fwd_data_o, mw_u_imm_o, wb_fwd_data_o;
    logic [MASK_W-1:0] dmem_byte_en_o;
    logic dmem_read_o, dmem_write_o, mw_load_i, wb_fwd_load_i;
    logic mw_ld_reg_o, mw_valid_o;

    int err_cnt;
    int cycle_cnt;
    logic [15:0] lfsr_q;

    rv32i_pipe_regs i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one Galois step per bit with lsb out first
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] exe_value(input logic [1:0] sel, input logic [XLEN-1:0] alu,
                                                  input logic br, input logic [XLEN-1:0] uimm);
        if (sel == FWD_BR) return {{(XLEN-1){1'b0}}, br};
        if (sel == FWD_UIMM) return uimm;
        return alu;
    endfunction

    function automatic logic [MASK_W-1:0] expect_mask(input logic rd, input logic wr,
                                                       input logic [2:0] f3, input logic [1:0] off);
        logic [MASK_W-1:0] m;
        m = '0;
        if (rd) begin
            if (f3 == F3_LW) m = 4'b1111;
            else if (f3 == F3_LH || f3 == F3_LHU) m = 4'b0011 << off;
            else if (f3 == F3_LB || f3 == F3_LBU) m = 4'b0001 << off;
        end else if (wr) begin
            if (f3 == F3_SW) m = 4'b1111;
            else if (f3 == F3_SH) m = 4'b0011 << off;
            else if (f3 == F3_SB) m = 4'b0001 << off;
        end
        return m;
    endfunction

    task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        err_cnt++;
        $display("FAILED %s expected %h actual %h", name, exp, act);
    endtask

    // reference model mirrors each DUT register stage
    logic [ORDER_W-1:0] m_order;
    logic m_fd_valid, m_de_valid, m_de_rd, m_de_wr, m_de_mar, m_de_memfwd, m_de_ld;
    logic [XLEN-1:0] m_fd_pc, m_de_pc, m_de_uimm, m_exe, m_addr, m_wdata, m_memfwd, m_wb;
    logic [XLEN-1:0] m_fd_instr, m_fd_pc_next, m_em_uimm, m_mw_uimm;
    logic [REG_ADDR_W-1:0] m_de_dst, m_em_dst, m_mw_dst;
    logic [1:0] m_de_sel;
    logic [2:0] m_de_f3;
    logic m_em_valid, m_exe_ok, m_sel_ok, m_em_memfwd, m_em_ld, m_addr_ok;
    logic [MASK_W-1:0] m_be;
    logic m_rd_stb, m_wr_stb, m_mw_valid, m_mw_ld, m_mw_ok, m_wb_ok, m_mw_ctl_ok;
    logic [XLEN-1:0] m_raw;

    assign m_raw = (m_de_mar == MAR_PC) ? m_de_pc : alu_out_i;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_order <= ORDER_RESET;
            m_fd_valid <= 1'b0;
            m_fd_pc <= PC_RESET;
            m_fd_instr <= '0;
            m_fd_pc_next <= PC_RESET;
            m_de_valid <= 1'b0;
            m_de_pc <= PC_RESET;
            m_de_rd <= 1'b0;
            m_de_wr <= 1'b0;
            m_de_ld <= 1'b0;
            m_em_valid <= 1'b0;
            m_em_ld <= 1'b0;
            m_exe_ok <= 1'b0;
            m_sel_ok <= 1'b0;
            m_addr_ok <= 1'b0;
            m_be <= '0;
            m_rd_stb <= 1'b0;
            m_wr_stb <= 1'b0;
            m_mw_valid <= 1'b0;
            m_mw_ld <= 1'b0;
            m_mw_ok <= 1'b0;
            m_mw_ctl_ok <= 1'b0;
            m_wb_ok <= 1'b0;
        end else begin
            if ((fd_load_i || spec_commit_i) && !fd_flush_i) m_order <= m_order + 64'd1;
            else if (fd_flush_i && !fd_load_i) m_order <= m_order - 64'd1;
            if (fd_flush_i) begin
                m_fd_valid <= 1'b0;
                m_fd_pc <= PC_RESET;
                m_fd_instr <= '0;
                m_fd_pc_next <= PC_RESET;
            end else if (fd_load_i) begin
                m_fd_valid <= 1'b1;
                m_fd_pc <= pc_i;
                m_fd_instr <= instr_i;
                m_fd_pc_next <= pc_next_i;
            end
            if (de_load_i) begin
                m_de_valid <= 1'b1;
                m_de_pc <= m_fd_pc;
                m_de_sel <= exefwd_sel_i;
                m_de_mar <= mar_sel_i;
                m_de_rd <= mem_read_i;
                m_de_wr <= mem_write_i;
                m_de_f3 <= mem_funct_i.load_f3;
                m_de_memfwd <= memfwd_sel_i;
                m_de_ld <= ld_reg_i;
                m_de_dst <= rd_i;
                m_de_uimm <= u_imm_i;
            end
            if (em_flush_i) begin
                m_em_valid <= 1'b0;
                m_exe <= '0;
                m_exe_ok <= 1'b1;
                m_em_ld <= 1'b0;
            end else if (em_load_i) begin
                m_em_valid <= 1'b1;
                m_exe <= exe_value(m_de_sel, alu_out_i, br_en_i, m_de_uimm);
                m_exe_ok <= m_de_valid;
                m_em_ld <= m_de_ld;
                m_em_memfwd <= m_de_memfwd;
                m_em_dst <= m_de_dst;
                m_em_uimm <= m_de_uimm;
                m_sel_ok <= m_de_valid;
                m_rd_stb <= m_de_rd;
                m_wr_stb <= m_de_wr;
                if (m_de_rd || m_de_wr) begin
                    m_be <= expect_mask(m_de_rd, m_de_wr, m_de_f3, m_raw[1:0]);
                    m_addr <= (m_de_f3 == F3_LW) ? m_raw : {m_raw[XLEN-1:2], 2'b00};
                    m_wdata <= rs2_data_i;
                    m_addr_ok <= 1'b1;
                end
            end
            if (mw_load_i) begin
                m_mw_valid <= 1'b1;
                m_mw_ld <= m_em_ld;
                m_mw_dst <= m_em_dst;
                m_mw_uimm <= m_em_uimm;
                m_mw_ctl_ok <= m_sel_ok;
                m_memfwd <= (m_em_memfwd == MEMFWD_EXE) ? m_exe : dmem_rdata_i;
                m_mw_ok <= m_sel_ok && (m_em_memfwd == MEMFWD_RDATA || m_exe_ok);
            end
            if (wb_fwd_load_i) begin
                m_wb <= wb_fwd_data_i;
                m_wb_ok <= 1'b1;
            end
        end
    end

    a_order: assert property (@(posedge clk) disable iff (rst) commit_order_o == m_order)
        else report_value("commit_order_o", m_order, commit_order_o);
    a_fd_valid: assert property (@(posedge clk) disable iff (rst) fd_valid_o == m_fd_valid)
        else report_value("fd_valid_o", 64'(m_fd_valid), 64'(fd_valid_o));
    a_pc: assert property (@(posedge clk) disable iff (rst) pc_o == m_fd_pc)
        else report_value("pc_o", 64'(m_fd_pc), 64'(pc_o));
    a_instr: assert property (@(posedge clk) disable iff (rst) instr_o == m_fd_instr)
        else report_value("instr_o", 64'(m_fd_instr), 64'(instr_o));
    a_pc_next: assert property (@(posedge clk) disable iff (rst) pc_next_o == m_fd_pc_next)
        else report_value("pc_next_o", 64'(m_fd_pc_next), 64'(pc_next_o));
    a_de_valid: assert property (@(posedge clk) disable iff (rst) de_valid_o == m_de_valid)
        else report_value("de_valid_o", 64'(m_de_valid), 64'(de_valid_o));
    a_em_valid: assert property (@(posedge clk) disable iff (rst) em_valid_o == m_em_valid)
        else report_value("em_valid_o", 64'(m_em_valid), 64'(em_valid_o));
    a_exe: assert property (@(posedge clk) disable iff (rst)
        m_exe_ok |-> i_dut.em_mw.exe_fwd_data == m_exe)
        else report_value("exe_fwd_data", 64'(m_exe), 64'(i_dut.em_mw.exe_fwd_data));
    a_addr: assert property (@(posedge clk) disable iff (rst) m_addr_ok |-> dmem_addr_o == m_addr)
        else report_value("dmem_addr_o", 64'(m_addr), 64'(dmem_addr_o));
    a_wdata: assert property (@(posedge clk) disable iff (rst)
        m_addr_ok |-> dmem_wdata_o == m_wdata)
        else report_value("dmem_wdata_o", 64'(m_wdata), 64'(dmem_wdata_o));
    a_be: assert property (@(posedge clk) disable iff (rst) dmem_byte_en_o == m_be)
        else report_value("dmem_byte_en_o", 64'(m_be), 64'(dmem_byte_en_o));
    a_rd_stb: assert property (@(posedge clk) disable iff (rst) dmem_read_o == m_rd_stb)
        else report_value("dmem_read_o", 64'(m_rd_stb), 64'(dmem_read_o));
    a_wr_stb: assert property (@(posedge clk) disable iff (rst) dmem_write_o == m_wr_stb)
        else report_value("dmem_write_o", 64'(m_wr_stb), 64'(dmem_write_o));
    a_memfwd: assert property (@(posedge clk) disable iff (rst)
        m_mw_ok |-> mem_fwd_data_o == m_memfwd)
        else report_value("mem_fwd_data_o", 64'(m_memfwd), 64'(mem_fwd_data_o));
    a_mw_valid: assert property (@(posedge clk) disable iff (rst) mw_valid_o == m_mw_valid)
        else report_value("mw_valid_o", 64'(m_mw_valid), 64'(mw_valid_o));
    a_mw_ld: assert property (@(posedge clk) disable iff (rst) mw_ld_reg_o == m_mw_ld)
        else report_value("mw_ld_reg_o", 64'(m_mw_ld), 64'(mw_ld_reg_o));
    a_mw_rd: assert property (@(posedge clk) disable iff (rst)
        m_mw_ctl_ok |-> mw_rd_o == m_mw_dst)
        else report_value("mw_rd_o", 64'(m_mw_dst), 64'(mw_rd_o));
    a_mw_uimm: assert property (@(posedge clk) disable iff (rst)
        m_mw_ctl_ok |-> mw_u_imm_o == m_mw_uimm)
        else report_value("mw_u_imm_o", 64'(m_mw_uimm), 64'(mw_u_imm_o));
    a_wb: assert property (@(posedge clk) disable iff (rst) m_wb_ok |-> wb_fwd_data_o == m_wb)
        else report_value("wb_fwd_data_o", 64'(m_wb), 64'(wb_fwd_data_o));

    task automatic drive_cycle();
        logic [31:0] r;
        logic [2:0] f3;
        r = take_bits(9);
        fd_load_i = r[0];
        spec_commit_i = r[1];
        fd_flush_i = (r[4:2] == 3'b111) && (m_order != ORDER_RESET); // never rewind below reset
        de_load_i = r[5];
        em_load_i = r[6];
        em_flush_i = (r[8:7] == 2'b11) && take_bits(1) == 32'd1;
        r = take_bits(9);
        mw_load_i = r[0];
        wb_fwd_load_i = r[1];
        exefwd_sel_i = r[3:2];
        mar_sel_i = r[4];
        mem_read_i = (r[6:5] == 2'b01);
        mem_write_i = (r[6:5] == 2'b10);
        memfwd_sel_i = r[7];
        ld_reg_i = r[8];
        r = take_bits(3);
        if (mem_write_i) f3 = (r[1:0] == 2'b11) ? F3_SW : {1'b0, r[1:0]};
        else f3 = (r[2:1] == 2'b11) ? F3_LW : {r[0], 1'b0, r[1]};
        mem_funct_i.load_f3 = f3;
        r = take_bits(6);
        rd_i = r[4:0];
        br_en_i = r[5];
        instr_i = take_bits(32);
        pc_i = take_bits(32);
        pc_next_i = take_bits(32);
        u_imm_i = take_bits(32);
        alu_out_i = take_bits(32);
        rs2_data_i = take_bits(32);
        dmem_rdata_i = take_bits(32);
        wb_fwd_data_i = take_bits(32);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d", err_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        lfsr_q = 16'd36;
        err_cnt = 0;
        cycle_cnt = 0;
        rst = 1'b1;
        {fd_load_i, fd_flush_i, spec_commit_i, de_load_i, em_load_i, em_flush_i} = '0;
        {mw_load_i, wb_fwd_load_i, mar_sel_i, mem_read_i, mem_write_i} = '0;
        {memfwd_sel_i, ld_reg_i, br_en_i, exefwd_sel_i, rd_i} = '0;
        mem_funct_i = '0;
        {instr_i, pc_i, pc_next_i, u_imm_i, alu_out_i} = '0;
        {rs2_data_i, dmem_rdata_i, wb_fwd_data_i} = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < STIM_CYCLES; i++) begin
            drive_cycle();
            @(negedge clk);
        end
        {fd_load_i, fd_flush_i, spec_commit_i, de_load_i, em_load_i, em_flush_i} = '0;
        repeat (3) @(negedge clk);
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== rv32i_pipe_regs.f ====
rtl/rv32i_pipe_pkg.sv
rtl/stage_if.sv
rtl/fetch_decode_reg.sv
rtl/decode_execute_reg.sv
rtl/execute_memory_reg.sv
rtl/memory_writeback_reg.sv
rtl/rv32i_pipe_regs.sv
tb/tb_rv32i_pipe_regs.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv32i_pipe_regs
RTL_TOP   ?= rv32i_pipe_regs
FILELIST  ?= rv32i_pipe_regs.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
